/* include/wb_consts.svh */
//----------------------------------------
// Address map and widths of the Wishbone front end
// Only two word addresses are decoded, no byte lanes
//----------------------------------------
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Address map
`define WB_BASE_ADDR   32'h3000_0000               // Loopback register
`define WB_STREAM_ADDR (`WB_BASE_ADDR + 32'd4)     // Accelerator port

//----------------------------------------
// Bus widths
//----------------------------------------
`define WB_DATA_W 32
`define WB_ADDR_W 32
`define WB_SEL_W  4

//----------------------------------------
// Sample format
//----------------------------------------
// Two signed samples share one bus word
`define SAMPLE_W 16

`endif

/* source/wb_bus_pkg.sv */
//----------------------------------------
// Bus-side types of the Wishbone adapter
//----------------------------------------
`default_nettype none

`include "wb_consts.svh"

package wb_bus_pkg;

  // Bus vectors
  typedef logic [`WB_DATA_W-1:0] wb_data_t;
  typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [`WB_SEL_W-1:0]  wb_sel_t;   // Accepted, not decoded

  //----------------------------------------
  // Adapter state machine
  //----------------------------------------
  // LOOP holds until the loopback read, DONE until the result read
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,   // Word in the butterfly
    DONE = 2'd2,   // Result waiting for a read
    LOOP = 2'd3    // Loopback value waiting for a read
  } adapter_state_e;

endpackage

`default_nettype wire

/* source/dsp_pkg.sv */
//----------------------------------------
// Sample-side types of the butterfly datapath
// A pair is one bus word, a in the upper half
//----------------------------------------
`default_nettype none

`include "wb_consts.svh"

package dsp_pkg;

  // One signed sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // Sum or difference of two samples, one bit wider
  typedef logic signed [`SAMPLE_W:0] sample_wide_t;

  // Packed pair, a in [31:16], b in [15:0]
  typedef logic [2*`SAMPLE_W-1:0] sample_pair_t;

endpackage

`default_nettype wire

/* source/wb_stream_ctrl.sv */
//----------------------------------------
// Address decode and adapter FSM, combinational ack
// Requests that do not fit the state are never acked
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "wb_consts.svh"

module wb_stream_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wbs_stb_i,
  input  logic                 wbs_cyc_i,
  input  logic                 wbs_we_i,
  input  wb_bus_pkg::wb_addr_t wbs_adr_i,
  input  logic                 result_val_i,
  output logic                 stream_val_o,
  output logic                 loop_we_o,
  output logic                 rd_sel_loop_o,
  output logic                 wbs_ack_o
);

  logic req;
  logic hit_loop;
  logic hit_stream;
  logic wr_loop;
  logic rd_loop;
  logic wr_stream;
  logic rd_stream;

  wb_bus_pkg::adapter_state_e state;
  wb_bus_pkg::adapter_state_e next_state;

  //----------------------------------------
  // Request decode
  //----------------------------------------
  assign req        = wbs_stb_i && wbs_cyc_i;
  assign hit_loop   = (wbs_adr_i == wb_bus_pkg::wb_addr_t'(`WB_BASE_ADDR));
  assign hit_stream = (wbs_adr_i == wb_bus_pkg::wb_addr_t'(`WB_STREAM_ADDR));

  assign wr_loop   = req &&  wbs_we_i && hit_loop;
  assign rd_loop   = req && !wbs_we_i && hit_loop;
  assign wr_stream = req &&  wbs_we_i && hit_stream;
  assign rd_stream = req && !wbs_we_i && hit_stream;

  //----------------------------------------
  // State register
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wb_bus_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Next state and strobes
  always_comb begin
    next_state    = state;
    stream_val_o  = 1'b0;
    loop_we_o     = 1'b0;
    rd_sel_loop_o = 1'b0;
    wbs_ack_o     = 1'b0;
    case (state)
      wb_bus_pkg::IDLE: begin
        if (wr_stream) begin
          stream_val_o = 1'b1;             // Ack waits for the result
          next_state   = wb_bus_pkg::BUSY;
        end else if (wr_loop) begin
          loop_we_o  = 1'b1;
          wbs_ack_o  = 1'b1;
          next_state = wb_bus_pkg::LOOP;
        end
      end
      wb_bus_pkg::BUSY: begin
        // Master still holds the stream write here
        if (result_val_i) begin
          wbs_ack_o  = 1'b1;
          next_state = wb_bus_pkg::DONE;
        end
      end
      wb_bus_pkg::DONE: begin
        if (rd_stream) begin
          wbs_ack_o  = 1'b1;               // Result register on the bus
          next_state = wb_bus_pkg::IDLE;
        end
      end
      wb_bus_pkg::LOOP: begin
        if (rd_loop) begin
          rd_sel_loop_o = 1'b1;
          wbs_ack_o     = 1'b1;
          next_state    = wb_bus_pkg::IDLE;
        end
      end
      default: begin
        next_state = wb_bus_pkg::IDLE;
      end
    endcase
  end

  //----------------------------------------
  // Checks
  //----------------------------------------
  // A new word enters the butterfly only from IDLE
  a_stream_val_idle: assert property (@(posedge clk) disable iff (reset)
    stream_val_o |-> (state == wb_bus_pkg::IDLE));

  // The BUSY ack relies on the master holding its request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    wbs_ack_o |-> (wbs_stb_i && wbs_cyc_i));

  // The butterfly answers only the word this FSM sent
  a_result_in_busy: assert property (@(posedge clk) disable iff (reset)
    result_val_i |-> (state == wb_bus_pkg::BUSY));

endmodule

`default_nettype wire

/* source/fft_butterfly.sv */
//----------------------------------------
// Radix-2 butterfly, two pipeline stages, 2 cycle latency
// Outputs (a+b)>>>1 and (a-b)>>>1, truncated toward -inf
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "wb_consts.svh"

module fft_butterfly (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val_i,
  input  dsp_pkg::sample_pair_t in_data_i,
  output logic                 out_val_o,
  output dsp_pkg::sample_pair_t out_data_o
);

  dsp_pkg::sample_t      a;
  dsp_pkg::sample_t      b;
  dsp_pkg::sample_wide_t sum_d;
  dsp_pkg::sample_wide_t diff_d;

  // Stage one registers
  logic                  s1_val;
  dsp_pkg::sample_wide_t s1_sum;
  dsp_pkg::sample_wide_t s1_diff;

  // Halved results
  dsp_pkg::sample_wide_t sum_half;
  dsp_pkg::sample_wide_t diff_half;

  //----------------------------------------
  // Stage one, widened add and subtract
  //----------------------------------------
  assign a = dsp_pkg::sample_t'(in_data_i[2*`SAMPLE_W-1:`SAMPLE_W]);
  assign b = dsp_pkg::sample_t'(in_data_i[`SAMPLE_W-1:0]);

  // One extra bit so neither result wraps
  assign sum_d  = dsp_pkg::sample_wide_t'(a) + dsp_pkg::sample_wide_t'(b);
  assign diff_d = dsp_pkg::sample_wide_t'(a) - dsp_pkg::sample_wide_t'(b);

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_val <= 1'b0;
    end else begin
      s1_val <= in_val_i;
    end
  end

  always_ff @(posedge clk) begin
    s1_sum  <= sum_d;
    s1_diff <= diff_d;
  end

  //----------------------------------------
  // Stage two, halve and pack
  //----------------------------------------
  assign sum_half  = s1_sum >>> 1;    // Fits back into SAMPLE_W bits
  assign diff_half = s1_diff >>> 1;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_val_o <= 1'b0;
    end else begin
      out_val_o <= s1_val;
    end
  end

  always_ff @(posedge clk) begin
    out_data_o <= {sum_half[`SAMPLE_W-1:0], diff_half[`SAMPLE_W-1:0]};
  end

  // Fixed latency, one word per cycle
  a_latency_two: assert property (@(posedge clk) disable iff (reset)
    in_val_i |-> ##2 out_val_o);

endmodule

`default_nettype wire

/* source/wb_data_regs.sv */
//----------------------------------------
// Loopback and result registers, read data mux
// Byte select is not applied, writes are full words
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wb_data_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  wb_bus_pkg::wb_data_t  wr_data_i,
  input  logic                  loop_we_i,
  input  logic                  result_val_i,
  input  dsp_pkg::sample_pair_t result_data_i,
  input  logic                  rd_sel_loop_i,
  output wb_bus_pkg::wb_data_t  rd_data_o
);

  wb_bus_pkg::wb_data_t loop_q;
  wb_bus_pkg::wb_data_t result_q;

  //----------------------------------------
  // Storage
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      loop_q <= '0;
    end else if (loop_we_i) begin
      loop_q <= wr_data_i;
    end
  end

  // Result held until the next stream word completes
  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= '0;
    end else if (result_val_i) begin
      result_q <= wb_bus_pkg::wb_data_t'(result_data_i);
    end
  end

  // Read mux
  assign rd_data_o = rd_sel_loop_i ? loop_q : result_q;

  // Loopback writes only happen in IDLE, results only in BUSY
  a_no_dual_write: assert property (@(posedge clk) disable iff (reset)
    !(loop_we_i && result_val_i));

endmodule

`default_nettype wire

/* source/wb_fft_top.sv */
//----------------------------------------
// Wishbone slave with loopback and butterfly port
// wbs_sel_i is accepted but not decoded
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module wb_fft_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wbs_stb_i,
  input  logic                 wbs_cyc_i,
  input  logic                 wbs_we_i,
  input  wb_bus_pkg::wb_sel_t  wbs_sel_i,   // Ignored, full words only
  input  wb_bus_pkg::wb_data_t wbs_dat_i,
  input  wb_bus_pkg::wb_addr_t wbs_adr_i,
  output logic                 wbs_ack_o,
  output wb_bus_pkg::wb_data_t wbs_dat_o
);

  logic                  stream_val;
  logic                  loop_we;
  logic                  rd_sel_loop;
  logic                  result_val;
  dsp_pkg::sample_pair_t result_data;

  wb_stream_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .wbs_stb_i     (wbs_stb_i),
    .wbs_cyc_i     (wbs_cyc_i),
    .wbs_we_i      (wbs_we_i),
    .wbs_adr_i     (wbs_adr_i),
    .result_val_i  (result_val),
    .stream_val_o  (stream_val),
    .loop_we_o     (loop_we),
    .rd_sel_loop_o (rd_sel_loop),
    .wbs_ack_o     (wbs_ack_o)
  );

  // Write data goes straight in as the sample pair
  fft_butterfly u_bfly (
    .clk        (clk),
    .reset      (reset),
    .in_val_i   (stream_val),
    .in_data_i  (wbs_dat_i),
    .out_val_o  (result_val),
    .out_data_o (result_data)
  );

  wb_data_regs u_regs (
    .clk           (clk),
    .reset         (reset),
    .wr_data_i     (wbs_dat_i),
    .loop_we_i     (loop_we),
    .result_val_i  (result_val),
    .result_data_i (result_data),
    .rd_sel_loop_i (rd_sel_loop),
    .rd_data_o     (wbs_dat_o)
  );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
//----------------------------------------
// Free-running testbench clock, starts low
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;   // Half period per toggle
    end
  end

endmodule

`default_nettype wire

/* tb/wb_fft_tb.sv */
//----------------------------------------
// Random Wishbone traffic against a model of loopback and butterfly
// Inputs change 1 ns after posedge, outputs sampled at negedge
//----------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "wb_consts.svh"

module wb_fft_tb;

  localparam int CLK_PERIOD    = 10;
  localparam int DRIVE_DLY     = 1;
  localparam int NUM_OPS       = 300;
  localparam int CYCLES_PER_OP = 10;
  localparam int WATCHDOG_NS   = (NUM_OPS * CYCLES_PER_OP + 200) * CLK_PERIOD;

  logic                 clk;
  logic                 reset;
  logic                 wbs_stb_i;
  logic                 wbs_cyc_i;
  logic                 wbs_we_i;
  wb_bus_pkg::wb_sel_t  wbs_sel_i;
  wb_bus_pkg::wb_data_t wbs_dat_i;
  wb_bus_pkg::wb_addr_t wbs_adr_i;
  logic                 wbs_ack_o;
  wb_bus_pkg::wb_data_t wbs_dat_o;

  // Model state
  logic [31:0] exp_loop;
  logic [31:0] exp_result;
  logic [31:0] rng;
  logic [3:0]  kind;
  logic [3:0]  sel_pattern;
  logic [31:0] word;
  int          op_idx;

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk_o(clk));

  wb_fft_top uut (
    .clk       (clk),
    .reset     (reset),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o)
  );

  //----------------------------------------
  // Helpers
  //----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ((a+b)>>>1, (a-b)>>>1), halves kept to 16 bits
  function automatic logic [31:0] butterfly_model(input logic [31:0] pair);
    int a_v;
    int b_v;
    int sum_h;
    int diff_h;
    a_v    = int'($signed(pair[31:16]));
    b_v    = int'($signed(pair[15:0]));
    sum_h  = (a_v + b_v) >>> 1;
    diff_h = (a_v - b_v) >>> 1;
    return {sum_h[15:0], diff_h[15:0]};
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  // Holds the request until ack or max_cycles, ack_cycle is -1 if none
  task automatic bus_request(input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input int max_cycles,
                             output int ack_cycle, output logic [31:0] rdata);
    int n;
    ack_cycle = -1;
    rdata     = '0;
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i  = we;
    wbs_adr_i = adr;
    wbs_dat_i = dat;
    wbs_sel_i = sel_pattern;   // Not decoded by the slave
    for (n = 0; n < max_cycles && ack_cycle < 0; n++) begin
      @(negedge clk);
      if (wbs_ack_o === 1'b1) begin
        ack_cycle = n;
        rdata     = wbs_dat_o;
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic check_ack(input int got, input int exp, input string what);
    assert (got >= 0)
      else stop_on_error($sformatf("No acknowledge seen for the %s", what));
    assert (got == exp)
      else stop_on_error($sformatf("error wbs_ack_o: %s acked in cycle %0h, expected %0h",
                                   what, got, exp));
  endtask

  task automatic check_data(input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_on_error($sformatf("error wbs_dat_o: got %h, expected %h", got, exp));
  endtask

  // Bus idle, read mux shows the result register
  task automatic check_idle_result();
    @(negedge clk);
    assert (wbs_ack_o === 1'b0)
      else stop_on_error($sformatf("error wbs_ack_o: got %h on an idle bus, expected 0",
                                   wbs_ack_o));
    check_data(wbs_dat_o, exp_result);
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  //----------------------------------------
  // Transactions
  //----------------------------------------
  task automatic loop_pair(input logic [31:0] data);
    int          got;
    logic [31:0] rd;
    check_idle_result();
    bus_request(1'b1, `WB_BASE_ADDR, data, 4, got, rd);
    check_ack(got, 0, "loopback write");
    exp_loop = data;
    bus_request(1'b0, `WB_BASE_ADDR, ~data, 4, got, rd);
    check_ack(got, 0, "loopback read");
    check_data(rd, exp_loop);
  endtask

  task automatic stream_pair(input logic [31:0] data);
    int          got;
    logic [31:0] rd;
    check_idle_result();
    bus_request(1'b1, `WB_STREAM_ADDR, data, 6, got, rd);
    check_ack(got, 2, "stream write");   // Butterfly latency
    exp_result = butterfly_model(data);
    bus_request(1'b0, `WB_STREAM_ADDR, ~data, 4, got, rd);
    check_ack(got, 0, "stream read");
    check_data(rd, exp_result);
  endtask

  task automatic unmapped_probe(input logic we, input logic [31:0] adr);
    int          got;
    logic [31:0] rd;
    check_idle_result();
    bus_request(we, adr, adr ^ 32'h5a5a_a5a5, 8, got, rd);
    assert (got < 0)
      else stop_on_error($sformatf("error wbs_ack_o: unmapped address %h acked in cycle %0h",
                                   adr, got));
  endtask

  //----------------------------------------
  // Stimulus
  //----------------------------------------
  initial begin
    reset       = 1'b1;
    wbs_stb_i   = 1'b0;
    wbs_cyc_i   = 1'b0;
    wbs_we_i    = 1'b0;
    wbs_sel_i   = '0;
    wbs_dat_i   = '0;
    wbs_adr_i   = '0;
    sel_pattern = 4'hf;
    exp_loop    = '0;
    exp_result  = '0;   // Result register clears on reset
    rng         = 32'd63;

    repeat (3) begin
      @(negedge clk);
      assert (wbs_ack_o === 1'b0)
        else stop_on_error($sformatf("error wbs_ack_o: got %h during reset, expected 0",
                                     wbs_ack_o));
    end
    @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;

    // Extreme sample values first
    loop_pair(32'hdead_beef);
    stream_pair(32'h8000_8000);
    stream_pair(32'h7fff_7fff);
    stream_pair(32'h8000_7fff);
    stream_pair(32'h7fff_8000);

    for (op_idx = 0; op_idx < NUM_OPS; op_idx++) begin
      rng         = xorshift32(rng);
      kind        = rng[3:0];
      sel_pattern = rng[7:4];
      rng         = xorshift32(rng);
      word        = rng;
      if (kind == 4'd0) begin
        rng = xorshift32(rng);
        unmapped_probe(rng[31], `WB_BASE_ADDR + 32'h8 + {22'd0, rng[7:0], 2'b00});
      end else if (kind[0]) begin
        loop_pair(word);
      end else begin
        rng = xorshift32(rng);
        if (rng[2:0] == 3'd0) word[31:16] = 16'h8000;
        if (rng[2:0] == 3'd1) word[31:16] = 16'h7fff;
        if (rng[5:3] == 3'd0) word[15:0] = 16'h8000;
        if (rng[5:3] == 3'd1) word[15:0] = 16'h7fff;
        stream_pair(word);
      end
    end

    check_idle_result();
    $display("No errors");
    $finish;
  end

  // Watchdog
  initial begin
    #WATCHDOG_NS;
    stop_on_error("Watchdog timeout, the test sequence did not finish in time");
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
source/wb_bus_pkg.sv
source/dsp_pkg.sv
source/wb_stream_ctrl.sv
source/fft_butterfly.sv
source/wb_data_regs.sv
source/wb_fft_top.sv
tb/tb_clock.sv
tb/wb_fft_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = wb_fft_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

.PHONY: sim clean

# A crash or an RTL assertion also counts as a failed run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
